// File: muldiv_msg_pkg.sv
//------------------------------
// port message types of the multiply/divide unit
// operands are signed 32-bit, results are 64-bit words
//------------------------------

package muldiv_msg_pkg;

  //------------------------------
  // function code
  //------------------------------

  // one bit is enough, unsigned variants are not supported
  typedef enum logic {
    MUL = 1'b0,
    DIV = 1'b1
  } muldiv_func_e;

  //------------------------------
  // request
  //------------------------------

  // 65 bits, func on top
  typedef struct packed {
    muldiv_func_e      func;
    logic signed [31:0] a;
    logic signed [31:0] b;
  } muldiv_req_t;

  //------------------------------
  // response
  //------------------------------

  // divider result, remainder in the upper half
  typedef struct packed {
    logic [31:0] rem;
    logic [31:0] quo;
  } div_pair_t;

  // same 64 bits, read by function code
  typedef union packed {
    logic [63:0] product;
    div_pair_t   pair;
  } muldiv_result_u;

  // 65 bits, func tells which view of result applies
  typedef struct packed {
    muldiv_func_e   func;
    muldiv_result_u result;
  } muldiv_resp_t;

endpackage

// File: muldiv_ctrl_pkg.sv
//------------------------------
// control types shared by the iterative units
// the mul control word is internal to the multiplier
//------------------------------

package muldiv_ctrl_pkg;

  // iteration FSM, same shape in both units
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } iter_state_e;

  //------------------------------
  // multiplier control word
  //------------------------------

  // sel fields: 0 loads initial value, 1 takes the shifted one
  typedef struct packed {
    logic a_en;
    logic a_sel;
    logic b_en;
    logic b_sel;
    // add the shifted multiplicand or hold
    logic add_sel;
    // 0 reloads 31, 1 decrements
    logic cntr_sel;
    // clears on load, accumulates in CALC
    logic result_en;
    // negate the product on the way out
    logic sign_sel;
  } mul_ctrl_t;

  //------------------------------
  // multiplier status word
  //------------------------------

  typedef struct packed {
    logic counter_is_zero;
    logic b_lsb;
    logic sign;
  } mul_status_t;

endpackage

// File: int_mul_dpath.sv
//------------------------------
// multiplier datapath, one add/shift step per enabled cycle
// works on magnitudes, sign applied at the output
//------------------------------

`timescale 1ns/1ps

module int_mul_dpath (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [31:0]               a,
  input  logic [31:0]               b,
  input  muldiv_ctrl_pkg::mul_ctrl_t   ctrl,
  output muldiv_ctrl_pkg::mul_status_t status,
  output logic [63:0]               product
);

  // operand magnitudes, 0x80000000 stays as unsigned 2^31
  logic [31:0] a_mag;
  logic [31:0] b_mag;

  // multiplicand shifts left, multiplier shifts right
  logic [63:0] a_reg;
  logic [31:0] b_reg;
  logic [63:0] result_reg;
  logic [4:0]  counter;
  logic        sign_reg;

  logic [63:0] a_next;
  logic [31:0] b_next;
  logic [63:0] add_out;
  logic [63:0] result_next;
  logic [4:0]  counter_next;

  assign a_mag = a[31] ? (~a + 32'd1) : a;
  assign b_mag = b[31] ? (~b + 32'd1) : b;

  //------------------------------
  // next values
  //------------------------------

  assign a_next = ctrl.a_sel ? (a_reg << 1) : {32'd0, a_mag};
  assign b_next = ctrl.b_sel ? (b_reg >> 1) : b_mag;

  // add only when the current multiplier bit is set
  assign add_out = ctrl.add_sel ? (result_reg + a_reg) : result_reg;
  // a_sel low means a fresh operation, so start from zero
  assign result_next = ctrl.a_sel ? add_out : 64'd0;

  assign counter_next = ctrl.cntr_sel ? (counter - 5'd1) : 5'd31;

  //------------------------------
  // registers
  //------------------------------

  always_ff @(posedge clk) begin
    if (ctrl.a_en) begin
      a_reg <= a_next;
    end
    if (ctrl.b_en) begin
      b_reg <= b_next;
    end
    if (ctrl.result_en) begin
      result_reg <= result_next;
    end
    // product sign captured at accept, operands may change afterwards
    if (ctrl.a_en && !ctrl.a_sel) begin
      sign_reg <= a[31] ^ b[31];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      counter <= 5'd31;
    end else begin
      counter <= counter_next;
    end
  end

  //------------------------------
  // outputs
  //------------------------------

  assign status.counter_is_zero = (counter == 5'd0);
  assign status.b_lsb           = b_reg[0];
  assign status.sign            = sign_reg;

  assign product = ctrl.sign_sel ? (~result_reg + 64'd1) : result_reg;

endmodule

// File: int_mul_ctrl.sv
//------------------------------
// multiplier control, IDLE/CALC/DONE
// one operation at a time, response held until taken
//------------------------------

`timescale 1ns/1ps

module int_mul_ctrl (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      req_val,
  output logic                      req_rdy,
  output logic                      resp_val,
  input  logic                      resp_rdy,
  input  muldiv_ctrl_pkg::mul_status_t status,
  output muldiv_ctrl_pkg::mul_ctrl_t   ctrl
);

  muldiv_ctrl_pkg::iter_state_e state;

  logic req_go;
  logic resp_go;

  // transfers, derived from state so no comb loop through the top
  assign req_go  = req_val && (state == muldiv_ctrl_pkg::IDLE);
  assign resp_go = resp_rdy && (state == muldiv_ctrl_pkg::DONE);

  //------------------------------
  // state register
  //------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= muldiv_ctrl_pkg::IDLE;
    end else begin
      case (state)
        muldiv_ctrl_pkg::IDLE: begin
          if (req_go) begin
            state <= muldiv_ctrl_pkg::CALC;
          end
        end
        // counter reads zero on the 32nd step
        muldiv_ctrl_pkg::CALC: begin
          if (status.counter_is_zero) begin
            state <= muldiv_ctrl_pkg::DONE;
          end
        end
        muldiv_ctrl_pkg::DONE: begin
          if (resp_go) begin
            state <= muldiv_ctrl_pkg::IDLE;
          end
        end
        default: begin
          state <= muldiv_ctrl_pkg::IDLE;
        end
      endcase
    end
  end

  //------------------------------
  // control word and handshake
  //------------------------------

  always_comb begin
    ctrl     = '0;
    req_rdy  = 1'b0;
    resp_val = 1'b0;
    case (state)
      muldiv_ctrl_pkg::IDLE: begin
        req_rdy = 1'b1;
        // load magnitudes and clear result, counter reloads 31
        ctrl.a_en      = req_go;
        ctrl.b_en      = req_go;
        ctrl.result_en = req_go;
      end
      muldiv_ctrl_pkg::CALC: begin
        ctrl.a_en      = 1'b1;
        ctrl.a_sel     = 1'b1;
        ctrl.b_en      = 1'b1;
        ctrl.b_sel     = 1'b1;
        ctrl.add_sel   = status.b_lsb;
        ctrl.cntr_sel  = 1'b1;
        ctrl.result_en = 1'b1;
      end
      muldiv_ctrl_pkg::DONE: begin
        resp_val      = 1'b1;
        ctrl.sign_sel = status.sign;
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

endmodule

// File: int_div_iterative.sv
//------------------------------
// signed restoring divider, one quotient bit per cycle
// divide by zero gives quo all ones and rem = dividend
//------------------------------

`timescale 1ns/1ps

module int_div_iterative (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         req_val,
  output logic                         req_rdy,
  input  logic [31:0]                  a,
  input  logic [31:0]                  b,
  output logic                         resp_val,
  input  logic                         resp_rdy,
  output muldiv_msg_pkg::muldiv_result_u result
);

  muldiv_ctrl_pkg::iter_state_e state;

  logic        req_go;
  logic        resp_go;
  logic        b_zero;
  logic [31:0] a_mag;
  logic [31:0] b_mag;

  // remainder in the upper half, quotient shifts in at the bottom
  logic [63:0] rq_reg;
  logic [31:0] b_mag_reg;
  logic [4:0]  counter;
  logic        neg_quo;
  logic        neg_rem;

  logic [63:0] shifted;
  logic [32:0] diff;
  logic [63:0] step_next;
  logic [31:0] rem_mag;
  logic [31:0] quo_mag;

  muldiv_msg_pkg::div_pair_t div_out;

  assign req_go  = req_val && (state == muldiv_ctrl_pkg::IDLE);
  assign resp_go = resp_rdy && (state == muldiv_ctrl_pkg::DONE);

  assign b_zero = (b == 32'd0);
  assign a_mag  = a[31] ? (~a + 32'd1) : a;
  assign b_mag  = b[31] ? (~b + 32'd1) : b;

  //------------------------------
  // restoring step
  //------------------------------

  // partial remainder stays below 2^31, so the shift never drops a bit
  assign shifted = {rq_reg[62:0], 1'b0};
  assign diff    = {1'b0, shifted[63:32]} - {1'b0, b_mag_reg};
  // borrow means the divisor did not fit, keep the shifted value
  assign step_next = diff[32] ? shifted : {diff[31:0], shifted[31:1], 1'b1};

  //------------------------------
  // FSM
  //------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= muldiv_ctrl_pkg::IDLE;
      counter <= 5'd31;
    end else begin
      case (state)
        muldiv_ctrl_pkg::IDLE: begin
          counter <= 5'd31;
          // zero divisor skips CALC
          if (req_go) begin
            state <= b_zero ? muldiv_ctrl_pkg::DONE : muldiv_ctrl_pkg::CALC;
          end
        end
        muldiv_ctrl_pkg::CALC: begin
          counter <= counter - 5'd1;
          if (counter == 5'd0) begin
            state <= muldiv_ctrl_pkg::DONE;
          end
        end
        muldiv_ctrl_pkg::DONE: begin
          if (resp_go) begin
            state <= muldiv_ctrl_pkg::IDLE;
          end
        end
        default: begin
          state <= muldiv_ctrl_pkg::IDLE;
        end
      endcase
    end
  end

  //------------------------------
  // payload registers
  //------------------------------

  always_ff @(posedge clk) begin
    if (req_go) begin
      b_mag_reg <= b_mag;
      // rem follows the dividend sign, quo negates on sign mismatch
      neg_rem   <= a[31];
      neg_quo   <= (a[31] ^ b[31]) && !b_zero;
      // zero divisor: final answer loaded straight away
      rq_reg    <= b_zero ? {a_mag, 32'hffff_ffff} : {32'd0, a_mag};
    end else if (state == muldiv_ctrl_pkg::CALC) begin
      rq_reg <= step_next;
    end
  end

  //------------------------------
  // sign correction and outputs
  //------------------------------

  assign rem_mag = rq_reg[63:32];
  assign quo_mag = rq_reg[31:0];

  // -2^31 / -1 wraps back to -2^31 here
  assign div_out.rem = neg_rem ? (~rem_mag + 32'd1) : rem_mag;
  assign div_out.quo = neg_quo ? (~quo_mag + 32'd1) : quo_mag;

  assign result.pair = div_out;

  assign req_rdy  = (state == muldiv_ctrl_pkg::IDLE);
  assign resp_val = (state == muldiv_ctrl_pkg::DONE);

endmodule

// File: int_muldiv.sv
//------------------------------
// multiply/divide unit, request steered by func
// multiplier wins when both responses are valid
//------------------------------

`timescale 1ns/1ps

module int_muldiv (
  input  logic                       clk,
  input  logic                       reset,
  input  muldiv_msg_pkg::muldiv_req_t  req,
  input  logic                       req_val,
  output logic                       req_rdy,
  output muldiv_msg_pkg::muldiv_resp_t resp,
  output logic                       resp_val,
  input  logic                       resp_rdy
);

  logic is_mul;

  logic mul_req_val;
  logic mul_req_rdy;
  logic mul_resp_val;
  logic mul_resp_rdy;
  logic div_req_val;
  logic div_req_rdy;
  logic div_resp_val;
  logic div_resp_rdy;

  logic [63:0] mul_product;

  muldiv_ctrl_pkg::mul_ctrl_t      mul_ctrl;
  muldiv_ctrl_pkg::mul_status_t    mul_status;
  muldiv_msg_pkg::muldiv_result_u  mul_result;
  muldiv_msg_pkg::muldiv_result_u  div_result;

  //------------------------------
  // request steering
  //------------------------------

  assign is_mul      = (req.func == muldiv_msg_pkg::MUL);
  assign mul_req_val = req_val && is_mul;
  assign div_req_val = req_val && !is_mul;
  // a request only waits on its own unit
  assign req_rdy     = is_mul ? mul_req_rdy : div_req_rdy;

  //------------------------------
  // units
  //------------------------------

  int_mul_ctrl mul_ctrl_inst (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy),
    .status   (mul_status),
    .ctrl     (mul_ctrl)
  );

  int_mul_dpath mul_dpath_inst (
    .clk     (clk),
    .reset   (reset),
    .a       (req.a),
    .b       (req.b),
    .ctrl    (mul_ctrl),
    .status  (mul_status),
    .product (mul_product)
  );

  assign mul_result.product = mul_product;

  int_div_iterative div_inst (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .a        (req.a),
    .b        (req.b),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy),
    .result   (div_result)
  );

  //------------------------------
  // response merge
  //------------------------------

  assign resp_val     = mul_resp_val | div_resp_val;
  assign mul_resp_rdy = resp_rdy;
  // divider holds in DONE while the multiplier owns the port
  assign div_resp_rdy = resp_rdy && !mul_resp_val;

  assign resp.func   = mul_resp_val ? muldiv_msg_pkg::MUL : muldiv_msg_pkg::DIV;
  assign resp.result = mul_resp_val ? mul_result : div_result;

endmodule

// File: int_muldiv_tb.sv
//------------------------------
// directed testbench for int_muldiv with inputs driven on the falling edge
// every wait gives up after TIMEOUT cycles and counts as an error
//------------------------------

`timescale 1ns/1ps

module int_muldiv_tb;

  localparam int TIMEOUT  = 100;
  localparam int SETTLE   = 10;
  // accept edge to transfer edge with resp_rdy high
  localparam int ITER_LAT = 33;
  localparam int ZDIV_LAT = 1;

  logic clk;
  logic reset;
  muldiv_msg_pkg::muldiv_req_t  req;
  logic req_val;
  logic req_rdy;
  muldiv_msg_pkg::muldiv_resp_t resp;
  logic resp_val;
  logic resp_rdy;

  integer seed;
  int     errors;
  int     tests_run;
  int     tests_failed;

  int_muldiv int_muldiv_inst (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  //------------------------------
  // reference model
  //------------------------------

  function automatic logic [63:0] mul_model(input logic signed [31:0] a,
                                            input logic signed [31:0] b);
    logic signed [63:0] ax;
    logic signed [63:0] bx;
    ax = {{32{a[31]}}, a};
    bx = {{32{b[31]}}, b};
    return ax * bx;
  endfunction

  // zero divisor and -2^31 / -1 follow the unit's rules, not the language
  function automatic muldiv_msg_pkg::div_pair_t div_model(input logic signed [31:0] a,
                                                          input logic signed [31:0] b);
    muldiv_msg_pkg::div_pair_t p;
    if (b == 0) begin
      p.quo = 32'hffff_ffff;
      p.rem = a;
    end else if (a == 32'sh8000_0000 && b == -1) begin
      p.quo = 32'h8000_0000;
      p.rem = 32'd0;
    end else begin
      p.quo = a / b;
      p.rem = a % b;
    end
    return p;
  endfunction

  task automatic check_resp(input muldiv_msg_pkg::muldiv_func_e func, input logic [31:0] a,
                            input logic [31:0] b, input muldiv_msg_pkg::muldiv_resp_t r);
    muldiv_msg_pkg::div_pair_t exp_pair;
    exp_pair = div_model(a, b);
    if (r.func !== func) begin
      $display("CHECK FAILED resp.func got %h exp %h", r.func, func);
      errors++;
    end
    if (func == muldiv_msg_pkg::MUL) begin
      if (r.result.product !== mul_model(a, b)) begin
        $display("CHECK FAILED resp.result.product got %h exp %h (a %h b %h)",
                 r.result.product, mul_model(a, b), a, b);
        errors++;
      end
    end else begin
      if (r.result.pair.quo !== exp_pair.quo) begin
        $display("CHECK FAILED resp.result.pair.quo got %h exp %h (a %h b %h)",
                 r.result.pair.quo, exp_pair.quo, a, b);
        errors++;
      end
      if (r.result.pair.rem !== exp_pair.rem) begin
        $display("CHECK FAILED resp.result.pair.rem got %h exp %h (a %h b %h)",
                 r.result.pair.rem, exp_pair.rem, a, b);
        errors++;
      end
    end
  endtask

  //------------------------------
  // handshake helpers
  //------------------------------

  // called just after a falling edge, returns on the falling edge after the accept
  task automatic drive_req(input muldiv_msg_pkg::muldiv_func_e func, input logic [31:0] a,
                           input logic [31:0] b, output logic ok);
    int waited;
    waited   = 0;
    req.func = func;
    req.a    = a;
    req.b    = b;
    req_val  = 1'b1;
    #SETTLE;
    while (!req_rdy && waited < TIMEOUT) begin
      @(negedge clk);
      #SETTLE;
      waited++;
    end
    ok = req_rdy;
    if (!ok) begin
      $display("ERROR: request was not accepted within %0d cycles", TIMEOUT);
      errors++;
    end else begin
      @(posedge clk);
    end
    @(negedge clk);
    req_val = 1'b0;
  endtask

  // n is the falling edge, counted from the accept, where resp_val is seen
  // the transfer edge follows it, so n is also the accept to transfer latency
  task automatic wait_resp(output int n, output logic ok);
    n = 1;
    while (!resp_val && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    ok = resp_val;
    if (!ok) begin
      $display("ERROR: no response arrived within %0d cycles", TIMEOUT);
      errors++;
    end
  endtask

  // sends one request with resp_rdy high and checks result and latency
  task automatic run_op(input muldiv_msg_pkg::muldiv_func_e func, input logic [31:0] a,
                        input logic [31:0] b, input int exp_lat);
    logic ok;
    int   n;
    muldiv_msg_pkg::muldiv_resp_t r;
    resp_rdy = 1'b1;
    n = 0;
    drive_req(func, a, b, ok);
    if (ok) begin
      wait_resp(n, ok);
    end
    if (ok) begin
      r = resp;
      if (n != exp_lat) begin
        $display("CHECK FAILED latency got %h exp %h", n, exp_lat);
        errors++;
      end
      check_resp(func, a, b, r);
      @(posedge clk);
      @(negedge clk);
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, errors - err_start);
    end
  endtask

  //------------------------------
  // tests
  //------------------------------

  task automatic test_reset();
    int err_start;
    err_start = errors;
    req.func = muldiv_msg_pkg::MUL;
    #SETTLE;
    if (req_rdy !== 1'b1) begin
      $display("CHECK FAILED req_rdy got %h exp %h", req_rdy, 1'b1);
      errors++;
    end
    req.func = muldiv_msg_pkg::DIV;
    #SETTLE;
    if (req_rdy !== 1'b1) begin
      $display("CHECK FAILED req_rdy got %h exp %h", req_rdy, 1'b1);
      errors++;
    end
    if (resp_val !== 1'b0) begin
      $display("CHECK FAILED resp_val got %h exp %h", resp_val, 1'b0);
      errors++;
    end
    @(negedge clk);
    report_test("reset", err_start);
  endtask

  task automatic test_mul_corners();
    int err_start;
    int i;
    logic [63:0] cases [12];
    err_start = errors;
    // operand pairs {a, b} with sign mixes, zero, one and -2^31
    cases = '{64'h00000003_00000005, 64'hfffffffd_00000005, 64'h00000003_fffffffb,
              64'hfffffffd_fffffffb, 64'h00000000_ffffcfc7, 64'h00000001_ffffffff,
              64'h80000000_80000000, 64'h80000000_00000001, 64'h80000000_ffffffff,
              64'h7fffffff_7fffffff, 64'h7fffffff_80000000, 64'hffffffff_ffffffff};
    for (i = 0; i < 12; i++) begin
      run_op(muldiv_msg_pkg::MUL, cases[i][63:32], cases[i][31:0], ITER_LAT);
    end
    for (i = 0; i < 4; i++) begin
      run_op(muldiv_msg_pkg::MUL, $random(seed), $random(seed), ITER_LAT);
    end
    report_test("mul_corners", err_start);
  endtask

  task automatic test_div();
    int err_start;
    int i;
    logic [31:0] a;
    logic [31:0] b;
    logic [63:0] cases [5];
    err_start = errors;
    cases = '{64'h80000000_ffffffff, 64'h00000007_fffffffe, 64'hfffffff9_00000002,
              64'hfffffff9_fffffffe, 64'h80000000_00000003};
    for (i = 0; i < 5; i++) begin
      run_op(muldiv_msg_pkg::DIV, cases[i][63:32], cases[i][31:0], ITER_LAT);
    end
    for (i = 0; i < 8; i++) begin
      a = $random(seed);
      b = $random(seed);
      // half of the divisors small, so quotients are not all tiny
      if (i % 2 == 1) begin
        b = $signed(b) >>> 16;
      end
      run_op(muldiv_msg_pkg::DIV, a, b, (b == 32'd0) ? ZDIV_LAT : ITER_LAT);
    end
    report_test("div", err_start);
  endtask

  task automatic test_div_zero();
    int err_start;
    err_start = errors;
    run_op(muldiv_msg_pkg::DIV, 32'd5, 32'd0, ZDIV_LAT);
    run_op(muldiv_msg_pkg::DIV, 32'hffff_fff7, 32'd0, ZDIV_LAT);
    run_op(muldiv_msg_pkg::DIV, 32'h8000_0000, 32'd0, ZDIV_LAT);
    run_op(muldiv_msg_pkg::DIV, 32'd0, 32'd0, ZDIV_LAT);
    report_test("div_zero", err_start);
  endtask

  // response held back for a random number of cycles
  task automatic hold_resp(input muldiv_msg_pkg::muldiv_func_e func);
    logic ok;
    int   n;
    int   hold;
    int   i;
    logic [31:0] a;
    logic [31:0] b;
    muldiv_msg_pkg::muldiv_resp_t r;
    a = $random(seed);
    b = $random(seed);
    hold = 1 + ($unsigned($random(seed)) % 8);
    resp_rdy = 1'b0;
    drive_req(func, a, b, ok);
    if (ok) begin
      wait_resp(n, ok);
    end
    if (ok) begin
      r = resp;
      check_resp(func, a, b, r);
      req.func = func;
      for (i = 0; i < hold; i++) begin
        @(negedge clk);
        #SETTLE;
        if (resp_val !== 1'b1) begin
          $display("CHECK FAILED resp_val got %h exp %h", resp_val, 1'b1);
          errors++;
        end
        if (resp !== r) begin
          $display("CHECK FAILED resp got %h exp %h", resp, r);
          errors++;
        end
        if (req_rdy !== 1'b0) begin
          $display("CHECK FAILED req_rdy got %h exp %h", req_rdy, 1'b0);
          errors++;
        end
      end
      @(negedge clk);
      resp_rdy = 1'b1;
      @(posedge clk);
      @(negedge clk);
      resp_rdy = 1'b0;
      #SETTLE;
      // unit back in IDLE after the transfer
      if (resp_val !== 1'b0) begin
        $display("CHECK FAILED resp_val got %h exp %h", resp_val, 1'b0);
        errors++;
      end
      if (req_rdy !== 1'b1) begin
        $display("CHECK FAILED req_rdy got %h exp %h", req_rdy, 1'b1);
        errors++;
      end
      @(negedge clk);
    end
  endtask

  task automatic test_backpressure();
    int err_start;
    err_start = errors;
    hold_resp(muldiv_msg_pkg::MUL);
    hold_resp(muldiv_msg_pkg::DIV);
    hold_resp(muldiv_msg_pkg::MUL);
    hold_resp(muldiv_msg_pkg::DIV);
    report_test("backpressure", err_start);
  endtask

  // divide issued first, multiply second, both held until the multiply is valid
  task automatic test_overlap();
    int err_start;
    int n;
    logic ok;
    logic [31:0] da;
    logic [31:0] db;
    logic [31:0] ma;
    logic [31:0] mb;
    muldiv_msg_pkg::muldiv_resp_t r;
    err_start = errors;
    da = $random(seed);
    db = $random(seed) | 32'd1;
    ma = $random(seed);
    mb = $random(seed);
    resp_rdy = 1'b0;
    drive_req(muldiv_msg_pkg::DIV, da, db, ok);
    if (ok) begin
      drive_req(muldiv_msg_pkg::MUL, ma, mb, ok);
    end
    n = 0;
    while (ok && !(resp_val && resp.func == muldiv_msg_pkg::MUL) && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (ok && !(resp_val && resp.func == muldiv_msg_pkg::MUL)) begin
      $display("ERROR: multiply response did not appear within %0d cycles", TIMEOUT);
      errors++;
      ok = 1'b0;
    end
    if (ok) begin
      r = resp;
      check_resp(muldiv_msg_pkg::MUL, ma, mb, r);
      resp_rdy = 1'b1;
      @(posedge clk);
      @(negedge clk);
      // divider result follows on the next cycle
      if (resp_val !== 1'b1) begin
        $display("CHECK FAILED resp_val got %h exp %h", resp_val, 1'b1);
        errors++;
      end
      r = resp;
      check_resp(muldiv_msg_pkg::DIV, da, db, r);
      @(posedge clk);
      @(negedge clk);
      resp_rdy = 1'b0;
      if (resp_val !== 1'b0) begin
        $display("CHECK FAILED resp_val got %h exp %h", resp_val, 1'b0);
        errors++;
      end
    end
    report_test("overlap", err_start);
  endtask

  //------------------------------
  // main sequence
  //------------------------------

  initial begin
    seed         = 32'hf437f2b7;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    reset        = 1'b1;
    req          = '0;
    req_val      = 1'b0;
    resp_rdy     = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    test_reset();
    test_mul_corners();
    test_div();
    test_div_zero();
    test_backpressure();
    test_overlap();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: int_muldiv.f
muldiv_msg_pkg.sv
muldiv_ctrl_pkg.sv
int_mul_dpath.sv
int_mul_ctrl.sv
int_div_iterative.sv
int_muldiv.sv
int_muldiv_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the int_muldiv testbench with Verilator
# pass or fail is taken from the simulation log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -rf "$OBJ" "$LOG"

verilator --binary --timing -j 0 \
  --top-module int_muldiv_tb \
  -Mdir "$OBJ" \
  -f int_muldiv.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/Vint_muldiv_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test OK" "$LOG"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see $LOG"
exit 1
